// File: verification/bottomGolden.txt
# op dst src bit data | expected rspData rspAddr bq4 bq5 bq7, all hex
# op 0 load 1 move 2 read 3 incPair 4 decPair 5 setBit 6 resBit 7 fetch 8 restart
7 0 0 0 00 00 0000 0 0 0
2 0 0 0 00 00 0000 0 0 0
2 1 0 0 00 00 0000 0 0 0
2 2 0 0 00 00 0000 0 0 0
2 3 0 0 00 00 0000 0 0 0
2 4 0 0 00 00 0000 0 0 0
2 5 0 0 00 00 0000 0 0 0
2 6 0 0 00 00 0000 0 0 0
3 3 0 0 00 00 ffff 0 0 0
0 0 0 0 5a 5a 0000 0 0 0
1 1 0 0 00 5a 0000 0 0 0
2 1 0 0 00 5a 0000 0 0 0
0 4 0 0 ff ff 0000 0 0 0
0 5 0 0 ff ff 0000 0 0 0
3 2 0 0 00 00 0000 0 0 0
4 2 0 0 00 00 ffff 0 0 0
0 6 0 0 90 90 0000 0 1 1
5 6 0 2 00 94 0000 1 1 1
6 6 0 7 00 14 0000 1 0 0
6 0 0 3 00 52 0000 1 0 0
7 0 0 0 00 00 0001 1 0 0
7 0 0 0 00 00 0002 1 0 0
8 0 0 5 00 00 0028 1 0 0
7 0 0 0 00 00 0028 1 0 0

// File: verilog.f
design/bottomPkg.sv
design/regFile.sv
design/addrRegs.sv
design/incDec.sv
design/operandLogic.sv
design/microOpControl.sv
design/bottomDatapath.sv
verification/bottomDatapathTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bottomDatapathTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASSTEXT  ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

// File: verification/bottomDatapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module bottomDatapathTb import bottomPkg::*; ();

	localparam int waitLimit = 200;	// Cycles per wait before giving up

	logic               CLK = 1'b0;
	logic               reset;
	logic               cmdValid;
	logic [opWidth-1:0] cmdOp;
	logic [2:0]         cmdDst;
	logic [2:0]         cmdSrc;
	logic [2:0]         cmdBit;
	logic [7:0]         cmdData;
	logic               rspReady = 1'b0;
	wire                cmdReady;
	wire                rspValid;
	wire  [7:0]         rspData;
	wire  [15:0]        rspAddr;
	wire  [15:0]        addrBus;
	wire                bq4;
	wire                bq5;
	wire                bq7;

	integer seed = 32'haa13_1b26;
	int     testCount = 0;
	int     failCount = 0;
	bit     aborted = 1'b0;

	bottomDatapath uut (
		.CLK(CLK), .reset(reset),
		.cmdValid(cmdValid), .cmdOp(cmdOp), .cmdDst(cmdDst), .cmdSrc(cmdSrc),
		.cmdBit(cmdBit), .cmdData(cmdData), .rspReady(rspReady),
		.cmdReady(cmdReady), .rspValid(rspValid), .rspData(rspData), .rspAddr(rspAddr),
		.addrBus(addrBus), .bq4(bq4), .bq5(bq5), .bq7(bq7)
	);

	always #50 CLK = ~CLK;

	// Sink stalls about one cycle in four
	always @(posedge CLK) begin
		rspReady <= (($random(seed) & 32'd3) != 32'd0);
	end

	task automatic runTest(input logic [opWidth-1:0] op, input logic [2:0] dst,
		input logic [2:0] src, input logic [2:0] bitIdx, input logic [7:0] data,
		input logic [7:0] expData, input logic [15:0] expAddr, input logic [2:0] expFlags);
		int          waitCount;
		logic [7:0]  heldData;
		logic [15:0] heldAddr;
		bit          ok;
		ok = 1'b1;
		@(posedge CLK);
		cmdOp    <= op;
		cmdDst   <= dst;
		cmdSrc   <= src;
		cmdBit   <= bitIdx;
		cmdData  <= data;
		cmdValid <= 1'b1;
		waitCount = 0;
		@(negedge CLK);
		while (!cmdReady) begin	// Ready at negedge means transfer on next edge
			waitCount++;
			if (waitCount > waitLimit) begin
				$display("Timeout: test %0d was never accepted", testCount);
				aborted = 1'b1;
				return;
			end
			@(negedge CLK);
		end
		@(posedge CLK);
		cmdValid <= 1'b0;
		waitCount = 0;
		@(negedge CLK);
		while (!rspValid) begin
			waitCount++;
			if (waitCount > waitLimit) begin
				$display("Timeout: test %0d never produced a response", testCount);
				aborted = 1'b1;
				return;
			end
			@(negedge CLK);
		end
		heldData = rspData;
		heldAddr = rspAddr;
		if ((op == opIncPair || op == opDecPair) && addrBus !== expAddr) begin
			$display("Mismatch at %0t: test %0d addrBus %h, stepped pair %h",
				$time, testCount, addrBus, expAddr);
			ok = 1'b0;
		end
		waitCount = 0;
		while (!rspReady) begin	// Held response must not move
			if (cmdReady) begin
				$display("Mismatch at %0t: test %0d cmdReady high while stalled",
					$time, testCount);
				ok = 1'b0;
			end
			waitCount++;
			if (waitCount > waitLimit) begin
				$display("Timeout: test %0d response was never taken", testCount);
				aborted = 1'b1;
				return;
			end
			@(negedge CLK);
			if (!rspValid || rspData !== heldData || rspAddr !== heldAddr) begin
				$display("Mismatch at %0t: test %0d response changed while stalled",
					$time, testCount);
				ok = 1'b0;
			end
		end
		if (!cmdReady) begin	// Slot drains on the next edge
			$display("Mismatch at %0t: test %0d cmdReady low while response drains",
				$time, testCount);
			ok = 1'b0;
		end
		if (heldData !== expData) begin
			$display("Mismatch at %0t: test %0d rspData %h, expected %h",
				$time, testCount, heldData, expData);
			ok = 1'b0;
		end
		if (heldAddr !== expAddr) begin
			$display("Mismatch at %0t: test %0d rspAddr %h, expected %h",
				$time, testCount, heldAddr, expAddr);
			ok = 1'b0;
		end
		if ({bq4, bq5, bq7} !== expFlags) begin
			$display("Mismatch at %0t: test %0d bq4/bq5/bq7 %b, expected %b",
				$time, testCount, {bq4, bq5, bq7}, expFlags);
			ok = 1'b0;
		end
		@(posedge CLK);	// Response leaves here
		@(negedge CLK);
		if (rspValid) begin
			$display("Mismatch at %0t: test %0d response seen twice", $time, testCount);
			ok = 1'b0;
		end
		if (!ok) begin
			failCount++;
		end
		$display("Test %0d op %0h %s", testCount, op, ok ? "ok" : "wrong");
	endtask

	initial begin
		int    fd;
		int    fields [10];
		string line;
		reset    = 1'b1;
		cmdValid = 1'b0;
		cmdOp    = '0;
		cmdDst   = 3'd0;
		cmdSrc   = 3'd0;
		cmdBit   = 3'd0;
		cmdData  = 8'h00;
		repeat (8) @(posedge CLK);
		reset <= 1'b0;
		fd = $fopen("verification/bottomGolden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0) begin
				break;
			end
			if (line.len() < 2 || line[0] == "#") begin	// Blank or column notes
				continue;
			end
			if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", fields[0], fields[1],
				fields[2], fields[3], fields[4], fields[5], fields[6], fields[7],
				fields[8], fields[9]) != 10) begin
				$display("Golden file line could not be parsed: %s", line);
				aborted = 1'b1;
				break;
			end
			testCount++;
			runTest(fields[0][3:0], fields[1][2:0], fields[2][2:0], fields[3][2:0],
				fields[4][7:0], fields[5][7:0], fields[6][15:0],
				{fields[7][0], fields[8][0], fields[9][0]});
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		if (testCount == 0) begin
			$display("No tests were read from the golden file");
			aborted = 1'b1;
		end
		$display("Ran %0d tests, %0d failed", testCount, failCount);
		if (!aborted && failCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: design/bottomDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module bottomDatapath import bottomPkg::*; (
	input  wire                CLK,
	input  wire                reset,
	input  wire                cmdValid,
	input  wire  [opWidth-1:0] cmdOp,
	input  wire  [2:0]         cmdDst,
	input  wire  [2:0]         cmdSrc,
	input  wire  [2:0]         cmdBit,
	input  wire  [7:0]         cmdData,
	input  wire                rspReady,
	output logic               cmdReady,
	output logic               rspValid,
	output logic [7:0]         rspData,
	output logic [15:0]        rspAddr,
	output logic [15:0]        addrBus,
	output logic               bq4,
	output logic               bq5,
	output logic               bq7
);

	logic [2:0]  rdSel;
	logic        wrEn;
	logic [2:0]  wrSel;
	logic [7:0]  wrData;
	logic [1:0]  pairSel;
	logic        pairWrEn;
	logic [15:0] pairWrData;
	logic [7:0]  rdData;
	logic [15:0] pairData;
	logic [7:0]  aValue;
	logic        spWrEn;
	logic        pcWrEn;
	logic [15:0] pcSpData;
	logic [15:0] sp;
	logic [15:0] pc;
	logic        stepEn;
	logic        decrement;
	logic [15:0] stepOperand;
	logic [15:0] stepResult;
	logic [7:0]  setResult;
	logic [7:0]  resResult;

	regFile regs (
		.CLK(CLK), .reset(reset),
		.rdSel(rdSel), .wrEn(wrEn), .wrSel(wrSel), .wrData(wrData),
		.pairSel(pairSel), .pairWrEn(pairWrEn), .pairWrData(pairWrData),
		.rdData(rdData), .pairData(pairData), .aValue(aValue)
	);

	addrRegs spPc (
		.CLK(CLK), .reset(reset),
		.spWrEn(spWrEn), .pcWrEn(pcWrEn), .wrData(pcSpData),
		.sp(sp), .pc(pc)
	);

	incDec stepper (
		.CLK(CLK), .reset(reset),
		.stepEn(stepEn), .decrement(decrement), .operand(stepOperand),
		.result(stepResult), .addrBus(addrBus)
	);

	// Bit ops work on the register read port
	operandLogic bitOps (
		.aValue(aValue), .operand(rdData), .bitSel(cmdBit),
		.bq4(bq4), .bq5(bq5), .bq7(bq7),
		.setResult(setResult), .resResult(resResult)
	);

	microOpControl ctrl (
		.CLK(CLK), .reset(reset),
		.cmdValid(cmdValid), .cmdReady(cmdReady), .cmdOp(cmdOp),
		.cmdDst(cmdDst), .cmdSrc(cmdSrc), .cmdBit(cmdBit), .cmdData(cmdData),
		.rspValid(rspValid), .rspReady(rspReady), .rspData(rspData), .rspAddr(rspAddr),
		.rdSel(rdSel), .wrEn(wrEn), .wrSel(wrSel), .wrData(wrData),
		.pairSel(pairSel), .pairWrEn(pairWrEn), .pairWrData(pairWrData),
		.spWrEn(spWrEn), .pcWrEn(pcWrEn), .pcSpData(pcSpData),
		.stepEn(stepEn), .decrement(decrement), .stepOperand(stepOperand),
		.rdData(rdData), .pairData(pairData), .sp(sp), .pc(pc),
		.stepResult(stepResult), .setResult(setResult), .resResult(resResult)
	);

endmodule

`default_nettype wire

// File: design/microOpControl.sv
`timescale 1ns/1ps
`default_nettype none

module microOpControl import bottomPkg::*; (
	input  wire                CLK,
	input  wire                reset,
	input  wire                cmdValid,
	output logic               cmdReady,
	input  wire  [opWidth-1:0] cmdOp,
	input  wire  [2:0]         cmdDst,
	input  wire  [2:0]         cmdSrc,
	input  wire  [2:0]         cmdBit,
	input  wire  [7:0]         cmdData,
	output logic               rspValid,
	input  wire                rspReady,
	output logic [7:0]         rspData,
	output logic [15:0]        rspAddr,
	output logic [2:0]         rdSel,
	output logic               wrEn,
	output logic [2:0]         wrSel,
	output logic [7:0]         wrData,
	output logic [1:0]         pairSel,
	output logic               pairWrEn,
	output logic [15:0]        pairWrData,
	output logic               spWrEn,
	output logic               pcWrEn,
	output logic [15:0]        pcSpData,
	output logic               stepEn,
	output logic               decrement,
	output logic [15:0]        stepOperand,
	input  wire  [7:0]         rdData,
	input  wire  [15:0]        pairData,
	input  wire  [15:0]        sp,
	input  wire  [15:0]        pc,
	input  wire  [15:0]        stepResult,
	input  wire  [7:0]         setResult,
	input  wire  [7:0]         resResult
);

	logic        accept;
	logic        isPairStep;
	logic        isRegWrite;
	logic [15:0] rstVector;	// Restart target, bit index times eight
	logic [7:0]  nextData;
	logic [15:0] nextAddr;

	assign cmdReady = ~rspValid | rspReady;	// Free slot or slot draining now
	assign accept   = cmdValid & cmdReady;

	assign isPairStep = (cmdOp == opIncPair) || (cmdOp == opDecPair);
	assign isRegWrite = (cmdOp == opLoadImm) || (cmdOp == opMove) ||
		(cmdOp == opSetBit) || (cmdOp == opResBit);
	assign rstVector  = {10'd0, cmdBit, 3'b000};

	// Register file side
	assign rdSel   = (cmdOp == opMove) ? cmdSrc : cmdDst;
	assign pairSel = cmdDst[1:0];
	assign wrSel   = cmdDst;
	assign wrEn    = accept & isRegWrite;

	always_comb begin
		case (cmdOp)
			opLoadImm: wrData = cmdData;
			opSetBit:  wrData = setResult;
			opResBit:  wrData = resResult;
			default:   wrData = rdData;	// Move source
		endcase
	end

	// Stepper operand, PC for fetch and SP or a file pair otherwise
	assign stepOperand = (cmdOp == opFetch) ? pc : ((pairSel == pairSP) ? sp : pairData);
	assign decrement   = (cmdOp == opDecPair);
	assign stepEn      = accept & (isPairStep | (cmdOp == opFetch));

	assign pairWrEn   = accept & isPairStep & (pairSel != pairSP);
	assign pairWrData = stepResult;
	assign spWrEn     = accept & isPairStep & (pairSel == pairSP);
	assign pcWrEn     = accept & ((cmdOp == opFetch) | (cmdOp == opRestart));
	assign pcSpData   = (cmdOp == opRestart) ? rstVector : stepResult;

	// Response content per op
	always_comb begin
		nextData = 8'h00;
		nextAddr = 16'h0000;
		case (cmdOp)
			opLoadImm, opMove, opSetBit, opResBit: nextData = wrData;
			opRead:               nextData = rdData;
			opIncPair, opDecPair: nextAddr = stepResult;
			opFetch:              nextAddr = pc;	// Old PC
			opRestart:            nextAddr = rstVector;
			default: ;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			rspValid <= 1'b0;
		end else if (accept) begin
			rspValid <= 1'b1;
		end else if (rspReady) begin
			rspValid <= 1'b0;
		end
	end

	// Payload holds while the sink stalls
	always_ff @(posedge CLK) begin
		if (accept) begin
			rspData <= nextData;
			rspAddr <= nextAddr;
		end
	end

endmodule

`default_nettype wire

// File: design/operandLogic.sv
`timescale 1ns/1ps
`default_nettype none

module operandLogic (
	input  wire        [7:0] aValue,
	input  wire        [7:0] operand,
	input  wire        [2:0] bitSel,
	output logic             bq4,
	output logic             bq5,
	output logic             bq7,
	output logic       [7:0] setResult,
	output logic       [7:0] resResult
);

	logic [7:0] bitMask;	// One-hot selected bit

	// Helper flags from A, used by the decimal adjust path
	assign bq4 = aValue[1] | aValue[2] | aValue[3];
	assign bq5 = aValue[5] | aValue[6] | aValue[7];
	assign bq7 = aValue[4] & aValue[7];

	always_comb begin
		bitMask = 8'h00;
		bitMask[bitSel] = 1'b1;
	end

	assign setResult = operand | bitMask;
	assign resResult = operand & ~bitMask;	// Masked like the DV operand

endmodule

`default_nettype wire

// File: design/incDec.sv
`timescale 1ns/1ps
`default_nettype none

module incDec (
	input  wire         CLK,
	input  wire         reset,
	input  wire         stepEn,
	input  wire         decrement,	// 1 steps down, 0 steps up
	input  wire  [15:0] operand,
	output logic [15:0] result,
	output logic [15:0] addrBus
);

	logic [15:0] stepped;

	// Plain 16-bit wrap, no paired 8-bit mode here
	assign stepped = decrement ? operand - 16'd1 : operand + 16'd1;
	assign result  = stepped;

	// Address bus holds the last produced address
	always_ff @(posedge CLK) begin
		if (reset) begin
			addrBus <= 16'h0000;
		end else if (stepEn) begin
			addrBus <= stepped;
		end
	end

endmodule

`default_nettype wire

// File: design/addrRegs.sv
`timescale 1ns/1ps
`default_nettype none

module addrRegs import bottomPkg::*; (
	input  wire         CLK,
	input  wire         reset,
	input  wire         spWrEn,
	input  wire         pcWrEn,
	input  wire  [15:0] wrData,	// Stepped address or restart vector
	output logic [15:0] sp,
	output logic [15:0] pc
);

	logic [15:0] spReg;
	logic [15:0] pcReg;

	// Stack pointer
	always_ff @(posedge CLK) begin
		if (reset) begin
			spReg <= spResetValue;	// Top of high RAM minus one
		end else if (spWrEn) begin
			spReg <= wrData;
		end
	end

	// Program counter
	always_ff @(posedge CLK) begin
		if (reset) begin
			pcReg <= pcResetValue;	// Boot starts at zero
		end else if (pcWrEn) begin
			pcReg <= wrData;
		end
	end

	assign sp = spReg;
	assign pc = pcReg;

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import bottomPkg::*; (
	input  wire         CLK,
	input  wire         reset,
	input  wire  [2:0]  rdSel,
	input  wire         wrEn,
	input  wire  [2:0]  wrSel,
	input  wire  [7:0]  wrData,
	input  wire  [1:0]  pairSel,
	input  wire         pairWrEn,
	input  wire  [15:0] pairWrData,
	output logic [7:0]  rdData,
	output logic [15:0] pairData,
	output logic [7:0]  aValue
);

	logic [7:0] regs [0:regA];	// B, C, D, E, H, L, A
	logic [2:0] pairHi;			// High byte register of the pair
	logic [2:0] pairLo;
	logic       pairInFile;		// SP lives in addrRegs

	// Pair index to register indices
	always_comb begin
		pairInFile = 1'b1;
		case (pairSel)
			pairBC: begin
				pairHi = regB;
				pairLo = regC;
			end
			pairDE: begin
				pairHi = regD;
				pairLo = regE;
			end
			pairHL: begin
				pairHi = regH;
				pairLo = regL;
			end
			default: begin
				pairHi = regB;
				pairLo = regC;
				pairInFile = 1'b0;
			end
		endcase
	end

	assign rdData   = (rdSel <= regA) ? regs[rdSel] : 8'h00;	// Index 7 reads zero
	assign pairData = pairInFile ? {regs[pairHi], regs[pairLo]} : 16'h0000;
	assign aValue   = regs[regA];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i <= regA; i++) begin
				regs[i] <= 8'h00;
			end
		end else begin
			if (wrEn && wrSel <= regA) begin
				regs[wrSel] <= wrData;
			end
			// Both halves move on the same edge
			if (pairWrEn && pairInFile) begin
				regs[pairHi] <= pairWrData[15:8];
				regs[pairLo] <= pairWrData[7:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/bottomPkg.sv
`default_nettype none

package bottomPkg;

	// Micro-op codes
	localparam int opWidth = 4;

	localparam logic [opWidth-1:0] opLoadImm = 4'd0;	// Immediate to register
	localparam logic [opWidth-1:0] opMove    = 4'd1;	// Register to register
	localparam logic [opWidth-1:0] opRead    = 4'd2;	// Report a register
	localparam logic [opWidth-1:0] opIncPair = 4'd3;	// Pair plus one
	localparam logic [opWidth-1:0] opDecPair = 4'd4;	// Pair minus one
	localparam logic [opWidth-1:0] opSetBit  = 4'd5;	// Force one bit high
	localparam logic [opWidth-1:0] opResBit  = 4'd6;	// Force one bit low
	localparam logic [opWidth-1:0] opFetch   = 4'd7;	// Report PC, then step it
	localparam logic [opWidth-1:0] opRestart = 4'd8;	// PC from restart vector

	// General register indices, 7 is a hole that reads as zero
	localparam logic [2:0] regB = 3'd0;
	localparam logic [2:0] regC = 3'd1;
	localparam logic [2:0] regD = 3'd2;
	localparam logic [2:0] regE = 3'd3;
	localparam logic [2:0] regH = 3'd4;
	localparam logic [2:0] regL = 3'd5;
	localparam logic [2:0] regA = 3'd6;

	// Register pair indices
	localparam logic [1:0] pairBC = 2'd0;
	localparam logic [1:0] pairDE = 2'd1;
	localparam logic [1:0] pairHL = 2'd2;
	localparam logic [1:0] pairSP = 2'd3;

	// Address register reset values
	localparam logic [15:0] spResetValue = 16'hFFFE;
	localparam logic [15:0] pcResetValue = 16'h0000;

endpackage

`default_nettype wire
